// ==== logic/audio_pkg.sv ====
// Audio mixer shared definitions

package audio_pkg;

	//////////////////////////////////////////////////
	// Sample and control widths
	//////////////////////////////////////////////////

	localparam int SAMPLE_W = 16;
	// One guard bit for the mixing sums
	localparam int ACC_W    = SAMPLE_W + 1;
	// Mute on top, shift amount below
	localparam int ATT_W    = 5;
	localparam int MIX_W    = 2;
	// Index 0 is left, index 1 is right
	localparam int NUM_CH   = 2;

	// Host opcode for volume attenuation
	localparam logic [7:0] CMD_VOLUME = 8'h26;

	//////////////////////////////////////////////////
	// Serializer timing
	//////////////////////////////////////////////////

	localparam int BCLK_HALF  = 4;
	localparam int FRAME_BITS = 32;
	localparam int DIV_W      = $clog2(BCLK_HALF);
	localparam int BIT_W      = $clog2(FRAME_BITS);

	localparam logic [DIV_W-1:0] DIV_LAST  = DIV_W'(BCLK_HALF - 1);
	localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(FRAME_BITS - 1);
	localparam logic [BIT_W-1:0] LEFT_LAST = BIT_W'(SAMPLE_W - 1);

	// Host word, read as a command or as volume data
	typedef struct packed {
		logic [7:0] rsvd;
		logic [7:0] opcode;
	} host_cmd_t;

	typedef struct packed {
		logic [10:0] rsvd;
		logic        mute;
		logic [3:0]  shift;
	} host_vol_t;

	typedef union packed {
		host_cmd_t cmd;
		host_vol_t vol;
	} host_word_u;

endpackage

// ==== logic/audio_sys_top.sv ====
// Audio mixing system top

module audio_sys_top (
	input  logic                           clk,
	input  logic                           resetd,
	input  logic                           i_io_uio,
	input  logic                           i_io_strobe,
	input  logic [15:0]                    i_io_din,
	input  logic [audio_pkg::MIX_W-1:0]    i_mix_mode,
	input  logic                           i_is_signed,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_core_l,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_core_r,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_linux_l,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_linux_r,
	output logic                           o_bclk,
	output logic                           o_lrclk,
	output logic                           o_sdata
);

	logic [audio_pkg::ATT_W-1:0]                         att;
	logic [audio_pkg::NUM_CH-1:0][audio_pkg::SAMPLE_W-1:0] core_s;
	logic [audio_pkg::NUM_CH-1:0][audio_pkg::SAMPLE_W-1:0] linux_s;
	logic [audio_pkg::NUM_CH-1:0][audio_pkg::SAMPLE_W-1:0] pre_s;
	logic [audio_pkg::NUM_CH-1:0][audio_pkg::SAMPLE_W-1:0] out_s;

	assign core_s  = {i_core_r, i_core_l};
	assign linux_s = {i_linux_r, i_linux_l};

	host_cmd_decoder u_host_cmd_decoder (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_att       (att)
	);

	//////////////////////////////////////////////////
	// Channel mixers
	//////////////////////////////////////////////////

	// Each channel crossfeeds from the other one
	for (genvar ch = 0; ch < audio_pkg::NUM_CH; ch++) begin : g_ch
		mix_channel u_mix_channel (
			.clk         (clk),
			.i_att       (att),
			.i_mix_mode  (i_mix_mode),
			.i_is_signed (i_is_signed),
			.i_core      (core_s[ch]),
			.i_linux     (linux_s[ch]),
			.i_pre       (pre_s[audio_pkg::NUM_CH-1-ch]),
			.o_pre       (pre_s[ch]),
			.o_out       (out_s[ch])
		);
	end

	i2s_serializer u_i2s_serializer (
		.clk      (clk),
		.resetd   (resetd),
		.i_sample (out_s),
		.o_bclk   (o_bclk),
		.o_lrclk  (o_lrclk),
		.o_sdata  (o_sdata)
	);

endmodule

// ==== logic/host_cmd_decoder.sv ====
// Host command decoder

module host_cmd_decoder (
	input  logic                          clk,
	input  logic                          resetd,
	input  logic                          i_io_uio,
	input  logic                          i_io_strobe,
	input  audio_pkg::host_word_u         i_io_din,
	output logic [audio_pkg::ATT_W-1:0]   o_att
);

	//////////////////////////////////////////////////
	// Command tracking
	//////////////////////////////////////////////////

	logic       has_cmd_q;
	logic [7:0] opcode_q;
	logic       cmd_wr;
	logic       vol_wr;

	// First strobe under select carries the opcode
	assign cmd_wr = i_io_uio & i_io_strobe & ~has_cmd_q;

	// Later strobes are data words for the latched opcode
	assign vol_wr = i_io_uio & i_io_strobe & has_cmd_q &
		(opcode_q == audio_pkg::CMD_VOLUME);

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd_q <= 1'b0;
			opcode_q  <= 8'h00;
		end else if (!i_io_uio) begin
			// Deselect drops any pending command
			has_cmd_q <= 1'b0;
			opcode_q  <= 8'h00;
		end else if (cmd_wr) begin
			has_cmd_q <= 1'b1;
			opcode_q  <= i_io_din.cmd.opcode;
		end
	end

	//////////////////////////////////////////////////
	// Attenuation register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			o_att <= '0;
		end else if (vol_wr) begin
			// Visible to the channels on the next cycle
			o_att <= {i_io_din.vol.mute, i_io_din.vol.shift};
		end
	end

endmodule

// ==== logic/i2s_serializer.sv ====
// Left-justified stereo serializer

module i2s_serializer (
	input  logic clk,
	input  logic resetd,
	input  logic [audio_pkg::NUM_CH-1:0][audio_pkg::SAMPLE_W-1:0] i_sample,
	output logic o_bclk,
	output logic o_lrclk,
	output logic o_sdata
);

	logic [audio_pkg::DIV_W-1:0]      div_q;
	logic [audio_pkg::BIT_W-1:0]      bit_q;
	logic [audio_pkg::FRAME_BITS-1:0] shift_q;
	logic                             fall_tick;
	logic                             frame_start;

	//////////////////////////////////////////////////
	// Bit clock divider
	//////////////////////////////////////////////////

	// Cycle on which the bit clock goes low
	assign fall_tick   = o_bclk & (div_q == audio_pkg::DIV_LAST);
	assign frame_start = fall_tick & (bit_q == audio_pkg::BIT_LAST);

	always_ff @(posedge clk) begin
		if (resetd) begin
			div_q  <= '0;
			o_bclk <= 1'b0;
		end else if (div_q == audio_pkg::DIV_LAST) begin
			div_q  <= '0;
			o_bclk <= ~o_bclk;
		end else begin
			div_q <= div_q + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Frame sequencing
	//////////////////////////////////////////////////

	// Bit counter starts at the last slot so the first fall opens a frame
	always_ff @(posedge clk) begin
		if (resetd) begin
			bit_q   <= audio_pkg::BIT_LAST;
			o_lrclk <= 1'b0;
			o_sdata <= 1'b0;
		end else if (frame_start) begin
			bit_q   <= '0;
			o_lrclk <= 1'b0;
			o_sdata <= i_sample[0][audio_pkg::SAMPLE_W-1];
		end else if (fall_tick) begin
			bit_q   <= bit_q + 1'b1;
			o_sdata <= shift_q[audio_pkg::FRAME_BITS-2];
			// Right word begins with its MSB
			if (bit_q == audio_pkg::LEFT_LAST)
				o_lrclk <= 1'b1;
		end
	end

	// Both channels captured together, left in the upper half
	always_ff @(posedge clk) begin
		if (frame_start)
			shift_q <= {i_sample[0], i_sample[1]};
		else if (fall_tick)
			shift_q <= shift_q << 1;
	end

endmodule

// ==== logic/mix_channel.sv ====
// Single audio mixing channel

module mix_channel (
	input  logic                           clk,
	input  logic [audio_pkg::ATT_W-1:0]    i_att,
	input  logic [audio_pkg::MIX_W-1:0]    i_mix_mode,
	input  logic                           i_is_signed,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_core,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_linux,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_pre,
	output logic [audio_pkg::SAMPLE_W-1:0] o_pre,
	output logic [audio_pkg::SAMPLE_W-1:0] o_out
);

	//////////////////////////////////////////////////
	// Core sample steadying
	//////////////////////////////////////////////////

	logic [audio_pkg::SAMPLE_W-1:0] hist0_q;
	logic [audio_pkg::SAMPLE_W-1:0] hist1_q;
	logic [audio_pkg::SAMPLE_W-1:0] hist2_q;
	logic [audio_pkg::SAMPLE_W-1:0] core_q;

	always_ff @(posedge clk) begin
		hist0_q <= i_core;
		hist1_q <= hist0_q;
		hist2_q <= hist1_q;
		// Glitches shorter than the history never pass
		if (hist1_q == hist2_q)
			core_q <= hist1_q;
	end

	//////////////////////////////////////////////////
	// Mixing pipeline
	//////////////////////////////////////////////////

	logic signed [audio_pkg::ACC_W-1:0] linux_ext;
	logic signed [audio_pkg::ACC_W-1:0] pre_ext;
	logic signed [audio_pkg::ACC_W-1:0] wide_q;
	logic signed [audio_pkg::ACC_W-1:0] sum_q;
	logic signed [audio_pkg::ACC_W-1:0] mix_q;
	logic signed [audio_pkg::ACC_W-1:0] att_q;

	assign linux_ext = {i_linux[audio_pkg::SAMPLE_W-1], i_linux};
	assign pre_ext   = {i_pre[audio_pkg::SAMPLE_W-1], i_pre};

	always_ff @(posedge clk) begin
		// Unsigned input is halved so it fits the signed range
		if (i_is_signed)
			wide_q <= {core_q[audio_pkg::SAMPLE_W-1], core_q};
		else
			wide_q <= {2'b00, core_q[audio_pkg::SAMPLE_W-1:1]};

		sum_q <= wide_q + linux_ext;
		o_pre <= sum_q[audio_pkg::ACC_W-1:1];

		// Crossfeed from the other channel's halved sum
		case (i_mix_mode)
			2'd0:    mix_q <= sum_q;
			2'd1:    mix_q <= sum_q - (sum_q >>> 3) + (pre_ext >>> 2);
			2'd2:    mix_q <= sum_q - (sum_q >>> 2) + (pre_ext >>> 1);
			default: mix_q <= (sum_q >>> 1) + pre_ext;
		endcase

		if (i_att[audio_pkg::ATT_W-1])
			att_q <= '0;
		else
			att_q <= mix_q >>> i_att[audio_pkg::ATT_W-2:0];

		// Saturate to 16 bits when the guard bit disagrees
		if (att_q[audio_pkg::ACC_W-1] != att_q[audio_pkg::SAMPLE_W-1])
			o_out <= {att_q[audio_pkg::ACC_W-1],
				{(audio_pkg::SAMPLE_W - 1){~att_q[audio_pkg::ACC_W-1]}}};
		else
			o_out <= att_q[audio_pkg::SAMPLE_W-1:0];
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the audio mixer regression with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_audio_sys \
	-Mdir obj_dir -o tb_audio_sys
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_audio_sys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== sim.f ====
logic/audio_pkg.sv
logic/host_cmd_decoder.sv
logic/mix_channel.sv
logic/i2s_serializer.sv
logic/audio_sys_top.sv
tests/audio_sys_asserts.sv
tests/tb_audio_sys.sv

// ==== tests/audio_patterns.hex ====
// mode sign att core_l core_r linux_l linux_r exp_l exp_r
// att bits 7:5 add host traffic: 1 deselected writes, 2 other opcode, 3 double data
// Sign conversion without crossfeed
0 1 00 1000 F000 0234 0100 1234 F100
0 0 00 8000 0000 0000 8000 4000 8000
0 0 00 FFFF 1235 0001 FFF0 7FFF 090A
0 1 00 0123 FEDC FF00 0200 0023 00DC
// Saturation
0 1 00 7FFF 8000 7FFF 8000 7FFF 8000
0 1 00 6000 A000 3000 D000 7FFF 8000
// Crossfeed modes
1 1 00 1000 0400 0000 0000 0E80 0580
2 1 00 2000 F000 0000 0000 1400 FC00
3 1 00 1000 0800 0100 FF00 0C00 0C00
1 1 00 FFF3 0065 0000 0000 0001 0057
2 0 00 C000 4000 E000 0000 3800 2800
3 1 00 C000 0200 0000 0000 E100 E100
// Attenuation and mute
0 1 03 1234 8000 0000 0000 0246 F000
0 1 0F 7FFF 8000 0000 0000 0000 FFFF
0 1 10 1234 4321 0000 0000 0000 0000
0 1 1F 8000 7FFF 0000 0000 0000 0000
0 1 00 0ABC F543 0000 0000 0ABC F543
// Host command filtering
0 1 22 0400 FC00 0000 0000 0100 FF00
0 1 41 0800 0600 0000 0000 0400 0300
0 1 64 1000 E000 0000 0000 0100 FE00

// ==== tests/audio_sys_asserts.sv ====
// Serial output timing checks

module audio_sys_asserts (
	input logic clk,
	input logic resetd,
	input logic i_bclk,
	input logic i_lrclk,
	input logic i_sdata
);

	timeunit 1ns;
	timeprecision 100ps;

	logic bclk_q;
	int   level_cnt_q;

	// Ticks spent at the current bit clock level
	always_ff @(posedge clk) begin
		bclk_q <= i_bclk;
		if (resetd) begin
			level_cnt_q <= 0;
		end else if (i_bclk != bclk_q) begin
			level_cnt_q <= 1;
		end else begin
			level_cnt_q <= level_cnt_q + 1;
		end
	end

	lrclk_on_fall: assert property (@(posedge clk) disable iff (resetd)
		$changed(i_lrclk) |-> $fell(i_bclk))
		else $error("o_lrclk changed without a falling o_bclk");

	sdata_on_fall: assert property (@(posedge clk) disable iff (resetd)
		$changed(i_sdata) |-> $fell(i_bclk))
		else $error("o_sdata changed without a falling o_bclk");

	bclk_half_exact: assert property (@(posedge clk) disable iff (resetd)
		(i_bclk != bclk_q) |-> (level_cnt_q == audio_pkg::BCLK_HALF))
		else $error("o_bclk level held %0d cycles", level_cnt_q);

	bclk_half_max: assert property (@(posedge clk) disable iff (resetd)
		level_cnt_q <= audio_pkg::BCLK_HALF)
		else $error("o_bclk stuck beyond a half period");

endmodule

bind audio_sys_top audio_sys_asserts u_audio_sys_asserts (
	.clk     (clk),
	.resetd  (resetd),
	.i_bclk  (o_bclk),
	.i_lrclk (o_lrclk),
	.i_sdata (o_sdata)
);

// ==== tests/tb_audio_sys.sv ====
// Audio mixer regression testbench

module tb_audio_sys;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_PAT     = 20;
	localparam int PAT_COLS    = 9;
	localparam int CYCLE_LIMIT = NUM_PAT * 3 * 256 + 2000;

	logic        clk;
	logic        resetd;
	logic        io_uio;
	logic        io_strobe;
	logic [15:0] io_din;
	logic [1:0]  mix_mode;
	logic        is_signed;
	logic [15:0] core_l;
	logic [15:0] core_r;
	logic [15:0] linux_l;
	logic [15:0] linux_r;
	logic        bclk;
	logic        lrclk;
	logic        sdata;

	logic [15:0] pat_mem [NUM_PAT*PAT_COLS];
	logic [15:0] cap_l;
	logic [15:0] cap_r;
	int          frame_cnt;
	int          cycles;
	int          value_errs = 0;
	int          frame_errs = 0;
	int          timeouts   = 0;

	audio_sys_top u_audio_sys_top (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_uio    (io_uio),
		.i_io_strobe (io_strobe),
		.i_io_din    (io_din),
		.i_mix_mode  (mix_mode),
		.i_is_signed (is_signed),
		.i_core_l    (core_l),
		.i_core_r    (core_r),
		.i_linux_l   (linux_l),
		.i_linux_r   (linux_r),
		.o_bclk      (bclk),
		.o_lrclk     (lrclk),
		.o_sdata     (sdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Host bus
	//////////////////////////////////////////////////

	task automatic select_host(input logic on);
		@(negedge clk);
		io_uio = on;
	endtask

	task automatic strobe_word(input audio_pkg::host_word_u word);
		@(negedge clk);
		io_din    = word;
		io_strobe = 1'b1;
		@(negedge clk);
		io_strobe = 1'b0;
	endtask

	// Bits 4:0 are the attenuation, bits 7:5 add stray host traffic
	task automatic set_volume(input logic [7:0] ctrl);
		audio_pkg::host_word_u cmd_w;
		audio_pkg::host_word_u vol_w;
		audio_pkg::host_word_u mute_w;
		cmd_w            = '0;
		cmd_w.cmd.opcode = audio_pkg::CMD_VOLUME;
		vol_w            = '0;
		vol_w.vol.mute   = ctrl[4];
		vol_w.vol.shift  = ctrl[3:0];
		mute_w           = '0;
		mute_w.vol.mute  = 1'b1;
		select_host(1'b1);
		strobe_word(cmd_w);
		// Junk data first, the real word must replace it
		if (ctrl[7:5] == 3'd3)
			strobe_word(mute_w);
		strobe_word(vol_w);
		select_host(1'b0);
		case (ctrl[7:5])
			3'd1: begin
				// Writes while deselected
				strobe_word(cmd_w);
				strobe_word(mute_w);
			end
			3'd2: begin
				cmd_w.cmd.opcode = 8'h13;
				select_host(1'b1);
				strobe_word(cmd_w);
				strobe_word(mute_w);
				select_host(1'b0);
			end
			default: ;
		endcase
	endtask

	//////////////////////////////////////////////////
	// Checks and reporting
	//////////////////////////////////////////////////

	task automatic check_sample(input int pat, input string side,
		input logic [15:0] expected, input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("ERR pattern %0d %s sample on o_sdata: expected %h, got %h",
				pat, side, expected, actual);
			value_errs++;
		end
	endtask

	task automatic finish_run();
		$display("Errors: value %0d, framing %0d, timeout %0d",
			value_errs, frame_errs, timeouts);
		if (value_errs + frame_errs + timeouts == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	endtask

	// Serial capture, left word while lrclk is low
	initial begin : capture
		logic [15:0] left_w;
		logic [15:0] right_w;
		int          left_bits;
		int          right_bits;
		left_w     = '0;
		right_w    = '0;
		left_bits  = 0;
		right_bits = 0;
		frame_cnt  = 0;
		wait (resetd == 1'b0);
		// First fall opens the first frame
		@(negedge bclk);
		forever begin
			@(posedge bclk);
			if (!lrclk) begin
				assert (right_bits == 0) else begin
					$display("Framing error: right word cut short after %0d bits",
						right_bits);
					frame_errs++;
					left_bits  = 0;
					right_bits = 0;
				end
				left_w = {left_w[14:0], sdata};
				left_bits++;
			end else begin
				right_w = {right_w[14:0], sdata};
				right_bits++;
				if (right_bits == 16) begin
					assert (left_bits == 16) else begin
						$display("Framing error: frame held %0d left bits instead of 16",
							left_bits);
						frame_errs++;
					end
					cap_l = left_w;
					cap_r = right_w;
					frame_cnt++;
					left_bits  = 0;
					right_bits = 0;
				end
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		timeouts++;
		$display("Timeout: the patterns did not finish within %0d cycles", CYCLE_LIMIT);
		finish_run();
	end

	initial begin : stimulus
		int p;
		int base;
		int start;
		resetd    = 1'b1;
		io_uio    = 1'b0;
		io_strobe = 1'b0;
		io_din    = '0;
		mix_mode  = '0;
		is_signed = 1'b0;
		core_l    = '0;
		core_r    = '0;
		linux_l   = '0;
		linux_r   = '0;
		$readmemh("tests/audio_patterns.hex", pat_mem);
		repeat (4) @(negedge clk);
		resetd = 1'b0;
		for (p = 0; p < NUM_PAT; p++) begin
			base = p * PAT_COLS;
			set_volume(pat_mem[base + 2][7:0]);
			@(negedge clk);
			mix_mode  = pat_mem[base][1:0];
			is_signed = pat_mem[base + 1][0];
			core_l    = pat_mem[base + 3];
			core_r    = pat_mem[base + 4];
			linux_l   = pat_mem[base + 5];
			linux_r   = pat_mem[base + 6];
			start     = frame_cnt;
			// Third completed frame was loaded after the pipeline settled
			wait (frame_cnt >= start + 3);
			check_sample(p, "left", pat_mem[base + 7], cap_l);
			check_sample(p, "right", pat_mem[base + 8], cap_r);
		end
		finish_run();
	end

endmodule
